// ==== all.f ====
source/tmap_pkg.sv
source/tmap_column_fetch.sv
source/tmap_tile_draw.sv
source/tmap_line_buffer.sv
source/tmap_layer.sv
bench/tmap_mem_model.sv
bench/tmap_layer_tb.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --assert -j 0 --top-module tmap_layer_tb -Mdir obj_dir -f all.f
	./obj_dir/Vtmap_layer_tb | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== bench/tmap_layer_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

/* Scroll tile-map layer testbench
   Directed line tests against a reference line built from the memory contents */

module tmap_layer_tb;

    // Each hs pulse counts as one line for the watchdog
    localparam int NUM_LINES  = 22;
    localparam int DONE_LIMIT = 3000;

    logic                clk;
    logic                rst;
    logic                hs;
    logic                page;
    logic                rand_delay;
    logic [3:0]          col_cfg;
    logic [8:0]          vrender;
    logic [8:0]          hdump;
    logic [11:0]         lut_addr;
    logic [15:0]         lut_data;
    logic [7:0]          col_addr;
    logic [7:0]          col_data;
    logic [19:2]         rom_addr;
    logic                rom_cs;
    logic                rom_ok;
    logic [31:0]         rom_data;
    tmap_pkg::pixel_t    pxl;
    logic                render_done;
    tmap_pkg::pixel_t    exp_line [512];
    int                  err_cnt;
    int                  chk_cnt;

    tmap_layer uut (
        .clk         (clk),
        .rst         (rst),
        .hs          (hs),
        .page        (page),
        .col_cfg     (col_cfg),
        .vrender     (vrender),
        .hdump       (hdump),
        .lut_addr    (lut_addr),
        .lut_data    (lut_data),
        .col_addr    (col_addr),
        .col_data    (col_data),
        .rom_addr    (rom_addr),
        .rom_cs      (rom_cs),
        .rom_ok      (rom_ok),
        .rom_data    (rom_data),
        .pxl         (pxl),
        .render_done (render_done)
    );

    tmap_mem_model mem (
        .clk        (clk),
        .rst        (rst),
        .rand_delay (rand_delay),
        .lut_addr   (lut_addr),
        .lut_data   (lut_data),
        .col_addr   (col_addr),
        .col_data   (col_data),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_pixel(input int x, input tmap_pkg::pixel_t got,
                               input tmap_pkg::pixel_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t pxl[%0d] got %h expected %h", $time, x, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Scroll pair p gets y = p * ystep and x = p * xstep
    task automatic set_scroll(input logic [7:0] xstep, input logic [7:0] ystep);
        for (int p = 0; p < 16; p++) begin
            mem.col_mem[{4'(p), 1'b0, 3'd0}] = 8'(p * ystep);
            mem.col_mem[{4'(p), 1'b1, 3'd0}] = 8'(p * xstep);
        end
    endtask

    // Junk in unused bits of code and attribute words
    task automatic load_map(input logic pg, input logic [12:0] base, input logic flip);
        logic [12:0] code;
        logic        hf;
        for (int r = 0; r < 16; r++) begin
            for (int c = 0; c < 32; c++) begin
                code = base + 13'(r * 32 + c);
                // Checkerboard of flipped tiles
                hf   = flip & 1'(r + c);
                mem.lut_mem[{pg, 1'b1, 1'b0, 4'(r), 5'(c)}] = {3'b101, code};
                mem.lut_mem[{pg, 1'b1, 1'b1, 4'(r), 5'(c)}] =
                    {1'b0, hf, 9'(c * 7), 5'(r + c + 1)};
            end
        end
    endtask

    // Expected line, columns drawn left to right so later ones win
    task automatic build_expected(input logic [8:0] v, input logic [3:0] cfg,
                                  input logic pg);
        logic [4:0]  first;
        logic [7:0]  ys;
        logic [7:0]  xs;
        logic [8:0]  ev;
        logic [8:0]  eh;
        logic [15:0] code_w;
        logic [15:0] attr_w;
        logic [3:0]  row;
        logic [8:0]  x0;
        logic [31:0] word;
        logic [3:0]  idx;
        logic [3:0]  nib;
        for (int a = 0; a < 512; a++) begin
            exp_line[9'(a)] = '0;
        end
        if (cfg != 4'd0 && v < 9'd224) begin
            // Config 1 starts at 0, others skip 2 * (16 - cfg) columns
            first = (cfg == 4'd1) ? 5'd0 : 5'(32 - 2 * int'(cfg));
            for (int c = int'(first); c < 32; c++) begin
                ys     = mem.col_mem[{4'(c / 2), 1'b0, 3'd0}];
                xs     = mem.col_mem[{4'(c / 2), 1'b1, 3'd0}];
                ev     = v + 9'(ys);
                eh     = 9'(c * 16) + 9'(xs);
                code_w = mem.lut_mem[{pg, 1'b1, 1'b0, ev[7:4], eh[8:4]}];
                attr_w = mem.lut_mem[{pg, 1'b1, 1'b1, ev[7:4], eh[8:4]}];
                row    = v[3:0] - ys[3:0];
                x0     = 9'(c * 16) - 9'(xs[3:0]);
                for (int p = 0; p < 16; p++) begin
                    word = mem.rom_mem[{code_w[12:0], row, 1'(p / 8)}];
                    // Leftmost pixel in the top nibble
                    nib  = 4'(word >> (28 - 4 * (p % 8)));
                    idx  = attr_w[14] ? 4'(15 - p) : 4'(p);
                    if (nib != 4'd0) begin
                        exp_line[x0 + 9'(idx)] = '{palette: attr_w[4:0], color: nib};
                    end
                end
            end
        end
    endtask

    // One dummy cycle at 511, then clear the whole write bank
    task automatic hsync_sweep();
        @(negedge clk);
        hs    = 1'b1;
        hdump = 9'd511;
        for (int i = 0; i < 512; i++) begin
            @(negedge clk);
            hdump = 9'(i);
        end
        @(negedge clk);
        check_bit("render_done", render_done, 1'b0);
        hs = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (render_done !== 1'b1 && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (render_done !== 1'b1) begin
            err_cnt++;
            $display("render_done did not rise within %0d cycles", DONE_LIMIT);
        end
    endtask

    task automatic render_line(input logic [8:0] v, input logic [3:0] cfg, input logic pg);
        @(negedge clk);
        vrender = v;
        col_cfg = cfg;
        page    = pg;
        build_expected(v, cfg, pg);
        hsync_sweep();
        wait_done();
    endtask

    // Next line draws nothing, previous one is read out
    task automatic check_line();
        @(negedge clk);
        col_cfg = 4'd0;
        hsync_sweep();
        for (int i = 0; i <= 256; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_pixel(i - 1, pxl, exp_line[9'(i - 1)]);
            end
            hdump = 9'(i);
        end
        wait_done();
    endtask

    task automatic test_reset();
        check_bit("rom_cs", rom_cs, 1'b0);
        check_bit("render_done", render_done, 1'b0);
        render_line(9'd0, 4'd0, 1'b0);
        check_line();
    endtask

    task automatic test_plain();
        set_scroll(8'd0, 8'd0);
        load_map(1'b0, 13'd16, 1'b0);
        render_line(9'd37, 4'd1, 1'b0);
        check_line();
    endtask

    task automatic test_scroll(input logic slow);
        @(negedge clk);
        rand_delay = slow;
        set_scroll(8'd37, 8'd91);
        load_map(1'b1, 13'd600, 1'b0);
        render_line(9'd100, 4'd1, 1'b1);
        check_line();
        // Leftmost two columns skipped
        render_line(9'd13, 4'd15, 1'b1);
        check_line();
    endtask

    // Full flipped line, then a sparse one over the same bank
    task automatic test_flip();
        load_map(1'b0, 13'd2000, 1'b1);
        render_line(9'd50, 4'd1, 1'b0);
        check_line();
        render_line(9'd50, 4'd14, 1'b0);
        check_line();
    endtask

    task automatic test_blank();
        render_line(9'd60, 4'd0, 1'b0);
        check_line();
        render_line(9'd224, 4'd1, 1'b0);
        check_line();
        render_line(9'd300, 4'd1, 1'b0);
        check_line();
    endtask

    initial begin
        rst        = 1'b1;
        hs         = 1'b0;
        page       = 1'b0;
        rand_delay = 1'b0;
        col_cfg    = 4'd0;
        vrender    = 9'd0;
        hdump      = 9'd0;
        err_cnt    = 0;
        chk_cnt    = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_plain();
        test_scroll(1'b0);
        test_flip();
        test_blank();
        test_scroll(1'b1);
        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // About 4000 cycles per line at most
    initial begin
        #(NUM_LINES * 4000 * 4);
        $display("watchdog expired after %0d lines of time, tests did not finish", NUM_LINES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tmap_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

/* Scroll layer memory model
   Tile map RAM, column scroll RAM and tile ROM with delayed rom_ok */

module tmap_mem_model (
    input  wire          clk,
    input  wire          rst,
    input  wire          rand_delay,
    input  wire  [11:0]  lut_addr,
    output logic [15:0]  lut_data,
    input  wire  [ 7:0]  col_addr,
    output logic [ 7:0]  col_data,
    input  wire  [19:2]  rom_addr,
    input  wire          rom_cs,
    output logic         rom_ok,
    output logic [31:0]  rom_data
);

    logic [15:0] lut_mem [4096];
    logic [ 7:0] col_mem [256];
    logic [31:0] rom_mem [262144];
    integer      seed = 32'hd7f3_70ae;
    logic [1:0]  wait_cnt;

    // Both RAMs answer in the same cycle
    assign lut_data = lut_mem[lut_addr];
    assign col_data = col_mem[col_addr];

    initial begin
        rom_ok   = 1'b0;
        rom_data = 32'd0;
        wait_cnt = 2'd0;
        // Background contents, tests overwrite what they use
        for (int a = 0; a < 4096; a++) begin
            lut_mem[12'(a)] = 16'(a * 40503) ^ 16'h3c5a;
        end
        for (int a = 0; a < 256; a++) begin
            col_mem[8'(a)] = 8'(a * 167 + 91);
        end
        // Odd multiplier keeps every address distinct, zero nibbles give gaps
        for (int a = 0; a < 262144; a++) begin
            rom_mem[18'(a)] = (32'(a) * 32'h9e37_79b1) ^ (32'(a) >> 5);
        end
    end

    // ROM answers 1 to 4 cycles after rom_cs, ok held for one cycle
    always @(negedge clk) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (rom_ok) begin
            rom_ok   <= 1'b0;
            wait_cnt <= rand_delay ? 2'($random(seed)) : 2'd0;
        end else if (rom_cs) begin
            if (wait_cnt == 2'd0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_mem[rom_addr];
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/tmap_layer.sv ====
`timescale 1ns/100ps
`default_nettype none

/* Scroll tile-map layer top
   Column fetcher, draw engine and own ping-pong line buffer */

module tmap_layer #(
    parameter int LINE_AW = 9
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      hs,
    input  wire                      page,
    input  wire  [ 3:0]              col_cfg,
    input  wire  [ 8:0]              vrender,
    input  wire  [ 8:0]              hdump,
    output logic [11:0]              lut_addr,
    input  wire  [15:0]              lut_data,
    output logic [ 7:0]              col_addr,
    input  wire  [ 7:0]              col_data,
    output logic [19:2]              rom_addr,
    output logic                     rom_cs,
    input  wire                      rom_ok,
    input  wire  [31:0]              rom_data,
    output tmap_pkg::pixel_t         pxl,
    output logic                     render_done
);

    tmap_pkg::tile_job_t job;
    tmap_pkg::pixel_t    buf_din;
    logic                job_valid;
    logic                job_ready;
    logic                fetch_done;
    logic                buf_we;
    logic [LINE_AW-1:0]  buf_addr;
    logic                hs_l;
    logic                bank;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hs_l        <= 1'b0;
            bank        <= 1'b0;
            render_done <= 1'b0;
        end else begin
            hs_l <= hs;
            // Swap banks at the start of hs
            if (hs && !hs_l) begin
                bank <= ~bank;
            end
            // Fetcher finished, nothing queued, draw engine idle
            if (hs) begin
                render_done <= 1'b0;
            end else if (fetch_done && !job_valid && job_ready) begin
                render_done <= 1'b1;
            end
        end
    end

    tmap_column_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .hs         (hs),
        .page       (page),
        .col_cfg    (col_cfg),
        .vrender    (vrender),
        .lut_data   (lut_data),
        .col_data   (col_data),
        .job_ready  (job_ready),
        .lut_addr   (lut_addr),
        .col_addr   (col_addr),
        .job_valid  (job_valid),
        .job        (job),
        .fetch_done (fetch_done)
    );

    tmap_tile_draw #(
        .LINE_AW (LINE_AW)
    ) u_draw (
        .clk       (clk),
        .rst       (rst),
        .job_valid (job_valid),
        .job       (job),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .job_ready (job_ready),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .buf_we    (buf_we),
        .buf_addr  (buf_addr),
        .buf_din   (buf_din)
    );

    tmap_line_buffer #(
        .LINE_AW (LINE_AW)
    ) u_linebuf (
        .clk      (clk),
        .rst      (rst),
        .hs       (hs),
        .bank     (bank),
        .hdump    (hdump[LINE_AW-1:0]),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_din  (buf_din),
        .pxl      (pxl)
    );

endmodule

`default_nettype wire

// ==== source/tmap_line_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

/* Scroll layer line buffer
   Two banks, draw or clear into one, registered read-out of the other */

module tmap_line_buffer #(
    parameter int LINE_AW = 9
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      hs,
    input  wire                      bank,
    input  wire  [LINE_AW-1:0]       hdump,
    input  wire                      buf_we,
    input  wire  [LINE_AW-1:0]       buf_addr,
    input  wire tmap_pkg::pixel_t    buf_din,
    output tmap_pkg::pixel_t         pxl
);

    localparam int DEPTH = 2 ** (LINE_AW + 1);

    tmap_pkg::pixel_t mem [DEPTH];
    logic             wr_en;
    logic [LINE_AW:0] wr_addr;
    tmap_pkg::pixel_t wr_data;
    logic [LINE_AW:0] rd_addr;

    // Clear follows hdump while hs is high
    assign wr_en   = hs || buf_we;
    assign wr_addr = {bank, hs ? hdump : buf_addr};
    assign wr_data = hs ? '0 : buf_din;
    // Previous line lives in the other bank
    assign rd_addr = {~bank, hdump};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle after hdump
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else begin
            pxl <= mem[rd_addr];
        end
    end

    // Draw engine must be done before the clear starts
    assert property (@(posedge clk) disable iff (rst) hs |-> !buf_we);

endmodule

`default_nettype wire

// ==== source/tmap_tile_draw.sv ====
`timescale 1ns/100ps
`default_nettype none

/* Scroll layer draw engine
   Reads two tile ROM words per job, writes opaque pixels to the line buffer */

module tmap_tile_draw #(
    parameter int LINE_AW = 9
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      job_valid,
    input  wire tmap_pkg::tile_job_t job,
    input  wire                      rom_ok,
    input  wire  [31:0]              rom_data,
    output logic                     job_ready,
    output logic [19:2]              rom_addr,
    output logic                     rom_cs,
    output logic                     buf_we,
    output logic [LINE_AW-1:0]       buf_addr,
    output tmap_pkg::pixel_t         buf_din
);

    tmap_pkg::tile_job_t          dr_job;
    logic                         busy;
    logic                         drawing;
    logic                         half;
    logic [2:0]                   cnt;
    logic [31:0]                  pix_word;
    logic [3:0]                   pix_off;
    logic [tmap_pkg::COLOR_W-1:0] nibble;
    logic                         take;
    logic                         word_in;

    // Idle only, so a single job is in flight here
    assign job_ready = !busy;
    assign take      = job_valid && job_ready;
    assign word_in   = rom_cs && rom_ok;

    // Row word address, half selects pixels 0-7 or 8-15
    assign rom_addr = {dr_job.code, dr_job.ysub, half};

    // Leftmost pixel sits in the top nibble
    assign nibble  = pix_word[31 -: tmap_pkg::COLOR_W];
    // Flip mirrors the index over both halves
    assign pix_off = {half, cnt} ^ {4{dr_job.hflip}};

    // Wraps around the bank
    assign buf_addr = LINE_AW'(dr_job.xpos) + LINE_AW'(pix_off);
    assign buf_we   = drawing && (nibble != '0);
    assign buf_din  = '{palette: dr_job.palette, color: nibble};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            rom_cs  <= 1'b0;
            drawing <= 1'b0;
            half    <= 1'b0;
            cnt     <= 3'd0;
        end else begin
            // New job starts with the first half
            if (take) begin
                busy   <= 1'b1;
                rom_cs <= 1'b1;
                half   <= 1'b0;
            end
            if (word_in) begin
                rom_cs  <= 1'b0;
                drawing <= 1'b1;
                cnt     <= 3'd0;
            end
            // Eight pixels per word, one per cycle
            if (drawing) begin
                cnt <= cnt + 3'd1;
                if (&cnt) begin
                    drawing <= 1'b0;
                    if (!half) begin
                        half   <= 1'b1;
                        rom_cs <= 1'b1;
                    end else begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    // Job copy and pixel shifter
    always_ff @(posedge clk) begin
        if (take) begin
            dr_job <= job;
        end
        if (word_in) begin
            pix_word <= rom_data;
        end else if (drawing) begin
            pix_word <= pix_word << tmap_pkg::COLOR_W;
        end
    end

    // ROM request held until acknowledged
    assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr));

endmodule

`default_nettype wire

// ==== source/tmap_column_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

/* Scroll layer column fetcher
   Reads scroll and map words per 16-pixel column, issues tile jobs */

module tmap_column_fetch (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      hs,
    input  wire                      page,
    input  wire  [ 3:0]              col_cfg,
    input  wire  [ 8:0]              vrender,
    input  wire  [15:0]              lut_data,
    input  wire  [ 7:0]              col_data,
    input  wire                      job_ready,
    output logic [11:0]              lut_addr,
    output logic [ 7:0]              col_addr,
    output logic                     job_valid,
    output tmap_pkg::tile_job_t      job,
    output logic                     fetch_done
);

    logic [4:0]                  col_cnt;
    logic [1:0]                  st;
    logic                        done;
    logic [7:0]                  yscr;
    logic [7:0]                  xscr;
    logic [tmap_pkg::CODE_W-1:0] code;
    logic [8:0]                  eff_h;
    logic [8:0]                  eff_v;
    logic [3:0]                  cfg_neg;
    logic [4:0]                  col_start;
    logic                        skip_line;
    logic                        advance;
    logic                        slot_free;
    logic                        take;

    // Config 1 starts at column 0, others skip the leftmost columns
    assign cfg_neg   = 4'd0 - col_cfg;
    assign col_start = (col_cfg == 4'd1) ? 5'd0 : {cfg_neg, 1'b0};
    assign skip_line = (vrender >= tmap_pkg::VISIBLE_LINES) || (col_cfg == 4'd0);

    // Scrolled map coordinates
    assign eff_v = vrender + {1'b0, yscr};
    assign eff_h = {col_cnt, 4'd0} + {1'b0, xscr};

    // st[0] picks code or attribute word
    assign lut_addr = {page, 1'b1, st[0], eff_v[7:4], eff_h[8:4]};
    // Scroll pair shared by two columns, st[0] picks y or x
    assign col_addr = {col_cnt[4:1], st[0], 3'd0};

    assign advance    = !hs && !done && !skip_line;
    // Output slot empty or emptying on this edge
    assign slot_free  = !job_valid || job_ready;
    assign take       = advance && (st == 2'd3) && slot_free;
    assign fetch_done = done;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            col_cnt   <= 5'd0;
            st        <= 2'd0;
            done      <= 1'b0;
            job_valid <= 1'b0;
        end else if (hs) begin
            // Restart for the next line
            col_cnt   <= col_start;
            st        <= 2'd0;
            done      <= 1'b0;
            job_valid <= 1'b0;
        end else begin
            if (job_valid && job_ready) begin
                job_valid <= 1'b0;
            end
            // Nothing to draw on this line
            if (!done && skip_line) begin
                done <= 1'b1;
            end
            // Step 3 stalls until the slot frees up
            if (advance && (st != 2'd3 || slot_free)) begin
                st <= st + 2'd1;
            end
            if (take) begin
                job_valid <= 1'b1;
                col_cnt   <= col_cnt + 5'd1;
                done      <= &col_cnt;
            end
        end
    end

    // Scroll, code and job payload
    always_ff @(posedge clk) begin
        if (advance && st == 2'd0) begin
            yscr <= col_data;
        end
        if (advance && st == 2'd1) begin
            xscr <= col_data;
        end
        if (advance && st == 2'd2) begin
            code <= lut_data[tmap_pkg::CODE_W-1:0];
        end
        if (take) begin
            job.code    <= code;
            job.hflip   <= lut_data[tmap_pkg::ATTR_HFLIP_BIT];
            job.palette <= lut_data[tmap_pkg::ATTR_PAL_LSB +: tmap_pkg::PAL_W];
            job.xpos    <= {col_cnt, 4'd0} - {5'd0, xscr[3:0]};
            job.ysub    <= vrender[3:0] - yscr[3:0];
        end
    end

    // Waiting job stays put until the draw engine takes it
    assert property (@(posedge clk) disable iff (rst || hs)
        job_valid && !job_ready |=> $stable(job));

endmodule

`default_nettype wire

// ==== source/tmap_pkg.sv ====
`default_nettype none

/* Scroll tile-map layer shared types
   Tile job and pixel formats, attribute word layout, visible line limit */

package tmap_pkg;

    // Field widths
    localparam int CODE_W  = 13;
    localparam int PAL_W   = 5;
    localparam int COLOR_W = 4;

    // Attribute word layout
    localparam int ATTR_PAL_LSB   = 0;
    localparam int ATTR_HFLIP_BIT = 14;

    // Lines from here on draw nothing
    localparam logic [8:0] VISIBLE_LINES = 9'd224;

    // One column tile handed to the draw engine
    typedef struct packed {
        logic [CODE_W-1:0] code;
        logic              hflip;
        logic [PAL_W-1:0]  palette;
        // Screen x of leftmost pixel
        logic [8:0]        xpos;
        // Row inside the tile
        logic [3:0]        ysub;
    } tile_job_t;

    // Line buffer entry
    // Color 0 is transparent, all zero is background
    typedef struct packed {
        logic [PAL_W-1:0]   palette;
        logic [COLOR_W-1:0] color;
    } pixel_t;

endpackage

`default_nettype wire
